// ==== irRxPkg.sv ====
/*
 * IR receiver shared definitions
 * Widths, FSM state encoding, decode tables and the OFF timeout rule
 */
`default_nettype none

package irRxPkg;

	//*********************************************************************
	// Widths
	//*********************************************************************
	localparam int cntWidth    = 16;	// Clock and carrier-cycle counts
	localparam int riseWidth   = 7;		// Rise counter
	localparam int memAdrWidth = 8;		// 256-byte code memory
	localparam int sampleMax   = 5;		// log2 of 32 samples
	localparam int sumWidth    = cntWidth + sampleMax;

	// OFF timeout rule on the carrier-cycle count
	localparam int toShortBit = 11;		// Setting 0, 0x0800 cycles
	localparam int toFieldLsb = 12;		// Top nibble compared with setting

	typedef enum logic [2:0] {
		sWait     = 3'd0,	// Idle, waiting first rise
		sOnCrrCnt = 3'd1,	// ON code while averaging period
		sOn       = 3'd2,	// ON code, average known
		sOffTemp  = 3'd3,	// Possible ON/OFF boundary
		sOff      = 3'd4,	// OFF code, first half period
		sOffIncOk = 3'd5	// OFF code, cycle may count
	} rxState_t;

	// Offset rises skipped before averaging
	function automatic logic [riseWidth-1:0] offsetLen(input logic [1:0] sel);
		return riseWidth'(1) << sel;	// 1, 2, 4, 8
	endfunction

	// Rises averaged for the carrier period
	function automatic logic [riseWidth-1:0] sampleLen(input logic [1:0] sel);
		return riseWidth'(4) << sel;	// 4, 8, 16, 32
	endfunction

endpackage

`default_nettype wire

// ==== irCountBus.sv ====
/*
 * Cycle counter bus
 * Enables and set-to-1 strobes toward the counters, count values back
 */
`default_nettype none

interface irCountBus;

	// Strobes from the control side
	logic clkCntEn;			// Clock count enable
	logic clkCntSet1;		// Clock count load 1
	logic crrCycCntEn;		// Carrier-cycle count enable
	logic crrCycCntSet1;	// Carrier-cycle count load 1
	logic riseCntEn;		// Rise count enable
	logic riseCntSet1;		// Rise count load 1

	// Values from the counters
	logic [irRxPkg::cntWidth-1:0]  clkCnt;
	logic [irRxPkg::cntWidth-1:0]  crrCycCnt;
	logic [irRxPkg::riseWidth-1:0] riseCnt;

	modport ctrl (
		output clkCntEn, clkCntSet1,
		output crrCycCntEn, crrCycCntSet1,
		output riseCntEn, riseCntSet1,
		input  clkCnt, crrCycCnt, riseCnt
	);

	modport cnt (
		input  clkCntEn, clkCntSet1,
		input  crrCycCntEn, crrCycCntSet1,
		input  riseCntEn, riseCntSet1,
		output clkCnt, crrCycCnt, riseCnt
	);

endinterface

`default_nettype wire

// ==== irCycleCounters.sv ====
/*
 * Cycle counters
 * Clock, carrier-cycle and rise counters, saturating, with load-to-1
 */
`default_nettype none

module irCycleCounters (
	input  wire    CLK_i,
	input  wire    RST_i,
	irCountBus.cnt cnt_i
);

	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i) begin
			cnt_i.clkCnt    <= '0;
			cnt_i.crrCycCnt <= '0;
			cnt_i.riseCnt   <= '0;
		end else begin
			if (cnt_i.clkCntSet1)	// Load wins over enable
				cnt_i.clkCnt <= irRxPkg::cntWidth'(1);
			else if (cnt_i.clkCntEn && !(&cnt_i.clkCnt))
				cnt_i.clkCnt <= cnt_i.clkCnt + 1'b1;

			if (cnt_i.crrCycCntSet1)
				cnt_i.crrCycCnt <= irRxPkg::cntWidth'(1);
			else if (cnt_i.crrCycCntEn && !(&cnt_i.crrCycCnt))
				cnt_i.crrCycCnt <= cnt_i.crrCycCnt + 1'b1;

			if (cnt_i.riseCntSet1)
				cnt_i.riseCnt <= irRxPkg::riseWidth'(1);
			else if (cnt_i.riseCntEn && !(&cnt_i.riseCnt))
				cnt_i.riseCnt <= cnt_i.riseCnt + 1'b1;
		end
	end

	// A saturated count stays saturated until reloaded
	property pNoWrap(set1, full);
		@(posedge CLK_i) disable iff (RST_i)
		!set1 && full |=> full;
	endproperty

	aClkNoWrap  : assert property (pNoWrap(cnt_i.clkCntSet1, &cnt_i.clkCnt));
	aCrrNoWrap  : assert property (pNoWrap(cnt_i.crrCycCntSet1, &cnt_i.crrCycCnt));
	aRiseNoWrap : assert property (pNoWrap(cnt_i.riseCntSet1, &cnt_i.riseCnt));

endmodule

`default_nettype wire

// ==== irCarrierAvg.sv ====
/*
 * Carrier period averaging
 * Skips offset rises, sums clocks over the sample rises, divides by shift
 */
`default_nettype none

module irCarrierAvg (
	input  wire                          CLK_i,
	input  wire                          RST_i,
	input  wire                          start_i,
	input  wire                          rxOn_i,
	input  wire                          rise_i,
	input  wire                          seek_i,
	input  wire  [1:0]                   offsetLen_i,
	input  wire  [1:0]                   sampleLen_i,
	irCountBus.ctrl                      bus_i,
	output logic [irRxPkg::cntWidth-1:0] crrCycAvg_o,
	output logic                         sampleDone_o
);

	logic                         offsetDone;	// Offset rises skipped
	logic                         offsetFull;
	logic [irRxPkg::sumWidth-1:0] clkSum;		// Covers up to 32 samples
	logic [irRxPkg::sumWidth-1:0] sumShift;
	logic [2:0]                   avgShift;		// log2 of sample count

	//*********************************************************************
	// Offset rises
	//*********************************************************************
	assign offsetFull = !offsetDone &&
		(bus_i.riseCnt == irRxPkg::offsetLen(offsetLen_i));

	// Restart at start and again once the offset is skipped
	assign bus_i.riseCntSet1 = start_i || (rxOn_i && offsetFull && rise_i);

	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i)
			offsetDone <= 1'b0;
		else if (!rxOn_i)
			offsetDone <= 1'b0;
		else if (offsetFull && rise_i)
			offsetDone <= 1'b1;
	end

	// Last sample rise
	assign sampleDone_o = offsetDone && rise_i &&
		(bus_i.riseCnt == irRxPkg::sampleLen(sampleLen_i));

	//*********************************************************************
	// Clock sum and average
	//*********************************************************************
	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i)
			clkSum <= '0;
		else if (start_i)	// Half the sample count for rounding
			clkSum <= irRxPkg::sumWidth'(irRxPkg::sampleLen(sampleLen_i) >> 1);
		else if (rxOn_i && seek_i && offsetDone)
			clkSum <= clkSum + 1'b1;
	end

	assign avgShift    = {1'b0, sampleLen_i} + 3'd2;	// 2 to 5
	assign sumShift    = clkSum >> avgShift;
	assign crrCycAvg_o = sumShift[irRxPkg::cntWidth-1:0];

endmodule

`default_nettype wire

// ==== irRxFsm.sv ====
/*
 * IR receive control
 * RXD sync and rise detect, ON/OFF code FSM, counter strobes, interrupt
 */
`default_nettype none

module irRxFsm (
	input  wire                          CLK_i,
	input  wire                          RST_i,
	input  wire                          start_i,
	input  wire                          stop_i,
	input  wire                          rxd_i,
	input  wire  [3:0]                   offTimeout_i,
	input  wire                          clear_i,
	input  wire  [irRxPkg::cntWidth-1:0] crrCycAvg_i,
	input  wire                          sampleDone_i,
	input  wire                          memFull_i,
	irCountBus.ctrl                      bus_o,
	output logic                         rise_o,
	output logic                         seek_o,
	output logic                         rxOn_o,
	output logic                         onCodeRdy_o,
	output logic                         offWrite_o,
	output logic                         offAdj_o,
	output logic                         codeEnd_o,
	output logic                         int_o
);

	logic              rxdP2, rxdP1, rxdS;	// RXD synchronizer
	logic              clrP, clrS;			// Interrupt clear sync
	irRxPkg::rxState_t state, nextState;
	logic              nSeek, nOnRdy, nEnd;
	logic              incDis, nIncDis;		// Blocks OFF cycle count on rise
	logic              clkFull, clkHalf, timeout, offState;

	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i) begin
			rxdP2 <= 1'b0;
			rxdP1 <= 1'b0;
			rxdS  <= 1'b0;
			clrP  <= 1'b0;
			clrS  <= 1'b0;
		end else begin
			rxdP2 <= rxd_i;
			rxdP1 <= rxdP2;
			rxdS  <= rxdP1;
			clrP  <= clear_i;
			clrS  <= clrP;
		end
	end

	assign rise_o   = rxdP1 && !rxdS;
	assign clkFull  = (bus_o.clkCnt == crrCycAvg_i);	// One carrier period
	assign clkHalf  = (bus_o.clkCnt == (crrCycAvg_i >> 1));
	assign offState = (state == irRxPkg::sOff) || (state == irRxPkg::sOffIncOk);
	// Count still holds the ON value in the cycle of onCodeRdy
	assign timeout  = !onCodeRdy_o && ((offTimeout_i == 4'd0) ?
		bus_o.crrCycCnt[irRxPkg::toShortBit] :
		(bus_o.crrCycCnt[irRxPkg::cntWidth-1:irRxPkg::toFieldLsb] == offTimeout_i));

	//*********************************************************************
	// Counter strobes and write requests
	//*********************************************************************
	assign bus_o.clkCntSet1 = rxOn_o && (rise_o || (clkFull &&
		((state == irRxPkg::sOn) || (state == irRxPkg::sOffIncOk))));
	assign bus_o.crrCycCntEn = rxOn_o && ((rise_o && !incDis) ||
		((state == irRxPkg::sOffIncOk) && clkFull));
	assign bus_o.crrCycCntSet1 = rxOn_o && ((rise_o && offState) || onCodeRdy_o ||
		((state == irRxPkg::sOnCrrCnt) && sampleDone_i));
	assign bus_o.riseCntEn = rxOn_o && rise_o;

	assign offWrite_o = offState && (rise_o || timeout);
	assign offAdj_o   = (state == irRxPkg::sOff) && rise_o;	// Rise already counted

	//*********************************************************************
	// Receiver FSM
	//*********************************************************************
	always_comb begin
		nextState = state;
		nSeek     = 1'b0;
		nOnRdy    = 1'b0;
		nEnd      = 1'b0;
		nIncDis   = 1'b0;
		case (state)
			irRxPkg::sWait: if (rxOn_o && rise_o) begin
				nSeek     = 1'b1;
				nextState = irRxPkg::sOnCrrCnt;
			end
			irRxPkg::sOnCrrCnt: begin
				nSeek = !stop_i && !sampleDone_i;
				if (stop_i)
					nEnd = 1'b1;
				else if (sampleDone_i)
					nextState = irRxPkg::sOn;
			end
			irRxPkg::sOn: begin
				if (stop_i || (rise_o && memFull_i))
					nEnd = 1'b1;
				else if (!rise_o && clkFull)
					nextState = irRxPkg::sOffTemp;
			end
			irRxPkg::sOffTemp: begin
				if (stop_i)
					nEnd = 1'b1;
				else if (rise_o)	// Still ON
					nextState = irRxPkg::sOn;
				else if (clkHalf) begin
					nOnRdy    = 1'b1;	// OFF declared, ON code out
					nextState = irRxPkg::sOffIncOk;
				end
			end
			irRxPkg::sOff: begin
				nIncDis = 1'b1;
				if (stop_i || timeout || (rise_o && memFull_i))
					nEnd = 1'b1;
				else if (rise_o)
					nextState = irRxPkg::sOn;
				else if (clkHalf) begin
					nIncDis   = 1'b0;
					nextState = irRxPkg::sOffIncOk;
				end
			end
			irRxPkg::sOffIncOk: begin
				if (stop_i || timeout || (rise_o && memFull_i))
					nEnd = 1'b1;
				else if (rise_o)	// Next ON code
					nextState = irRxPkg::sOn;
				else if (clkFull)
					nextState = irRxPkg::sOff;
			end
			default: nextState = irRxPkg::sWait;
		endcase
		if (nEnd)
			nextState = irRxPkg::sWait;
	end

	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i) begin
			state       <= irRxPkg::sWait;
			seek_o      <= 1'b0;
			onCodeRdy_o <= 1'b0;
			codeEnd_o   <= 1'b0;
			incDis      <= 1'b0;
		end else begin
			state       <= nextState;
			seek_o      <= nSeek;
			onCodeRdy_o <= nOnRdy;
			codeEnd_o   <= nEnd;
			incDis      <= nIncDis;
		end
	end

	//*********************************************************************
	// Receive flag, clock enable and interrupt
	//*********************************************************************
	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i) begin
			rxOn_o         <= 1'b0;
			bus_o.clkCntEn <= 1'b0;
			int_o          <= 1'b0;
		end else begin
			if (start_i)
				rxOn_o <= 1'b1;
			else if (codeEnd_o)
				rxOn_o <= 1'b0;
			if (codeEnd_o)
				bus_o.clkCntEn <= 1'b0;
			else if (rxOn_o && rise_o)	// Runs from the first rise
				bus_o.clkCntEn <= 1'b1;
			if (codeEnd_o)
				int_o <= 1'b1;
			else if (clrS)
				int_o <= 1'b0;
		end
	end

	aStateLegal : assert property (@(posedge CLK_i) disable iff (RST_i)
		state inside {irRxPkg::sWait, irRxPkg::sOnCrrCnt, irRxPkg::sOn,
		irRxPkg::sOffTemp, irRxPkg::sOff, irRxPkg::sOffIncOk});

	aEndOnce : assert property (@(posedge CLK_i) disable iff (RST_i)
		codeEnd_o |=> !codeEnd_o);

endmodule

`default_nettype wire

// ==== irCodeWriter.sv ====
/*
 * Code memory writer
 * Two-byte code writes LSB first, write address, end address latch
 */
`default_nettype none

module irCodeWriter (
	input  wire                             CLK_i,
	input  wire                             RST_i,
	input  wire                             rxOn_i,
	input  wire                             onCodeRdy_i,
	input  wire                             offWrite_i,
	input  wire                             offAdj_i,
	input  wire                             codeEnd_i,
	input  wire  [irRxPkg::cntWidth-1:0]    crrCycCnt_i,
	input  wire  [irRxPkg::memAdrWidth-1:0] limitAdr_i,
	input  wire  [irRxPkg::memAdrWidth-1:0] rdAdr_i,
	output logic [7:0]                      rdData_o,
	output logic                            memFull_o,
	output logic [irRxPkg::memAdrWidth-1:0] codeEndAdr_o
);

	logic [7:0]                      mem [2**irRxPkg::memAdrWidth];
	logic [irRxPkg::memAdrWidth-1:0] wrAdr;
	logic [irRxPkg::cntWidth-1:0]    codeVal;
	logic [7:0]                      msbByte;
	logic [7:0]                      wrData;
	logic                            wrFirst;	// LSB byte cycle
	logic                            wrSecond;	// MSB byte cycle
	logic                            memWe;

	// OFF code ended by a rise is one count high
	assign codeVal   = offAdj_i ? crrCycCnt_i - 1'b1 : crrCycCnt_i;
	// No room left for a two-byte code
	assign memFull_o = (wrAdr >= limitAdr_i - 1'b1);

	assign wrFirst = (onCodeRdy_i || offWrite_i) && !memFull_o;
	assign memWe   = wrFirst || wrSecond;	// 2-cycle write pulse
	assign wrData  = wrSecond ? msbByte : codeVal[7:0];

	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i)
			wrSecond <= 1'b0;
		else
			wrSecond <= wrFirst;
	end

	// MSB kept from the same count as the LSB
	always_ff @(posedge CLK_i) begin
		if (wrFirst)
			msbByte <= codeVal[15:8];
	end

	//*********************************************************************
	// Addresses
	//*********************************************************************
	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i) begin
			wrAdr        <= '0;
			codeEndAdr_o <= '0;
		end else begin
			if (!rxOn_i)	// Rewinds between receptions
				wrAdr <= '0;
			else if (memWe)
				wrAdr <= wrAdr + 1'b1;
			if (codeEnd_i)	// Past a byte still being written
				codeEndAdr_o <= memWe ? wrAdr + 1'b1 : wrAdr;
		end
	end

	always_ff @(posedge CLK_i) begin
		if (memWe)
			mem[wrAdr] <= wrData;
	end

	assign rdData_o = mem[rdAdr_i];	// Host read port

	// Neither byte of a code lands on the limit
	aNoLimitWrite : assert property (@(posedge CLK_i) disable iff (RST_i)
		wrFirst |-> (wrAdr != limitAdr_i) ##1 (wrAdr != limitAdr_i));

endmodule

`default_nettype wire

// ==== irRxTop.sv ====
/*
 * IR remote receiver top level
 * Carrier averaging, ON/OFF code FSM, cycle counters and code memory
 */
`default_nettype none

module irRxTop (
	input  wire                             CLK_i,
	input  wire                             RST_i,
	input  wire                             start_i,		// Start strobe
	input  wire                             stop_i,			// Stop strobe
	input  wire                             rxd_i,			// Demodulated carrier
	input  wire  [1:0]                      offsetLen_i,	// 1, 2, 4, 8 rises
	input  wire  [1:0]                      sampleLen_i,	// 4, 8, 16, 32 rises
	input  wire  [3:0]                      offTimeout_i,
	input  wire  [irRxPkg::memAdrWidth-1:0] limitAdr_i,
	input  wire  [irRxPkg::memAdrWidth-1:0] rdAdr_i,
	input  wire                             clear_i,		// Interrupt clear
	output logic                            rxOn_o,
	output logic                            int_o,
	output logic [irRxPkg::memAdrWidth-1:0] codeEndAdr_o,
	output logic [7:0]                      rdData_o
);

	logic                         rise, seek;
	logic [irRxPkg::cntWidth-1:0] crrCycAvg;
	logic                         sampleDone;
	logic                         memFull;
	logic                         onCodeRdy, offWrite, offAdj, codeEnd;

	irCountBus countBus ();

	irCycleCounters irCycleCounters_i (
		.CLK_i (CLK_i),
		.RST_i (RST_i),
		.cnt_i (countBus)
	);

	irCarrierAvg irCarrierAvg_i (
		.CLK_i        (CLK_i),
		.RST_i        (RST_i),
		.start_i      (start_i),
		.rxOn_i       (rxOn_o),
		.rise_i       (rise),
		.seek_i       (seek),
		.offsetLen_i  (offsetLen_i),
		.sampleLen_i  (sampleLen_i),
		.bus_i        (countBus),
		.crrCycAvg_o  (crrCycAvg),
		.sampleDone_o (sampleDone)
	);

	irRxFsm irRxFsm_i (
		.CLK_i        (CLK_i),
		.RST_i        (RST_i),
		.start_i      (start_i),
		.stop_i       (stop_i),
		.rxd_i        (rxd_i),
		.offTimeout_i (offTimeout_i),
		.clear_i      (clear_i),
		.crrCycAvg_i  (crrCycAvg),
		.sampleDone_i (sampleDone),
		.memFull_i    (memFull),
		.bus_o        (countBus),
		.rise_o       (rise),
		.seek_o       (seek),
		.rxOn_o       (rxOn_o),
		.onCodeRdy_o  (onCodeRdy),
		.offWrite_o   (offWrite),
		.offAdj_o     (offAdj),
		.codeEnd_o    (codeEnd),
		.int_o        (int_o)
	);

	irCodeWriter irCodeWriter_i (
		.CLK_i        (CLK_i),
		.RST_i        (RST_i),
		.rxOn_i       (rxOn_o),
		.onCodeRdy_i  (onCodeRdy),
		.offWrite_i   (offWrite),
		.offAdj_i     (offAdj),
		.codeEnd_i    (codeEnd),
		.crrCycCnt_i  (countBus.crrCycCnt),
		.limitAdr_i   (limitAdr_i),
		.rdAdr_i      (rdAdr_i),
		.rdData_o     (rdData_o),
		.memFull_o    (memFull),
		.codeEndAdr_o (codeEndAdr_o)
	);

endmodule

`default_nettype wire

// ==== tbIrRx.sv ====
/*
 * IR receiver testbench
 * Random carrier frames, code memory readback, timeout, stop and limit checks
 */
`default_nettype none

module tbIrRx;

	timeunit 1ns;
	timeprecision 100ps;

	logic                            clk = 1'b0;
	logic                            rst;
	logic                            start, stop, rxd, clear;
	logic [1:0]                      offsetLen, sampleLen;
	logic [3:0]                      offTimeout;
	logic [irRxPkg::memAdrWidth-1:0] limitAdr, rdAdr, codeEndAdr;
	logic                            rxOn, irq;
	logic [7:0]                      rdData;

	logic [31:0] lfsr = 32'hf004e4e8;	// Galois LFSR state
	int          errCount = 0;
	int          testsRun = 0;
	int          testsFailed = 0;
	int          cycleCnt = 0;
	int          runLimit = 32'h7fffffff;	// Replaced once frames are drawn
	string       testName;

	// Frame plan, period P in clocks, burst N in periods, gap G in clocks
	int pA = 20;
	int nA [4];
	int gA [3];
	int p5, n5, p6;
	int n6 [3];
	int g6 [2];

	irRxTop irRxTop_i (
		.CLK_i        (clk),
		.RST_i        (rst),
		.start_i      (start),
		.stop_i       (stop),
		.rxd_i        (rxd),
		.offsetLen_i  (offsetLen),
		.sampleLen_i  (sampleLen),
		.offTimeout_i (offTimeout),
		.limitAdr_i   (limitAdr),
		.rdAdr_i      (rdAdr),
		.clear_i      (clear),
		.rxOn_o       (rxOn),
		.int_o        (irq),
		.codeEndAdr_o (codeEndAdr),
		.rdData_o     (rdData)
	);

	always #5 clk = ~clk;	// 10 ns period

	// Run limit watchdog
	always @(posedge clk) begin
		cycleCnt++;
		if (cycleCnt >= runLimit) begin
			$display("Run stopped after %0d cycles without finishing", cycleCnt);
			$display("Test failures found");
			$finish;
		end
	end

	//*********************************************************************
	// Random numbers and reference rules
	//*********************************************************************
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic int drawBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsrNext(lfsr);
		end
		return v;
	endfunction

	function automatic int roundDiv(input int num, input int den);
		return (num + den / 2) / den;	// OFF code in carrier cycles
	endfunction

	//*********************************************************************
	// Checks and reporting
	//*********************************************************************
	task automatic checkNear(input string what, input int expV, input int actV);
		assert ((actV >= expV - 1) && (actV <= expV + 1)) else begin
			$display("ERROR %s %s: expected %0d (+/-1), actual %0d",
				testName, what, expV, actV);
			errCount++;
		end
	endtask

	task automatic checkEq(input string what, input int expV, input int actV);
		assert (actV == expV) else begin
			$display("ERROR %s %s: expected %0d, actual %0d", testName, what, expV, actV);
			errCount++;
		end
	endtask

	task automatic checkCond(input logic cond, input string msg);
		assert (cond) else begin
			$display("%s failed: %s", testName, msg);
			errCount++;
		end
	endtask

	task automatic finishTest(input int errBefore);
		testsRun++;
		if (errCount == errBefore) begin
			$display("Test %s: PASS", testName);
		end else begin
			testsFailed++;
			$display("Test %s: FAIL", testName);
		end
	endtask

	//*********************************************************************
	// Stimulus, all driven on the falling edge
	//*********************************************************************
	task automatic startRx();
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	// N carrier periods at 50% duty, optional stop pulse at period stopAt
	task automatic driveBurst(input int n, input int p, input int stopAt);
		for (int i = 0; i < n; i++) begin
			for (int c = 0; c < p; c++) begin
				rxd  = (c < p / 2);
				stop = (i == stopAt) && (c == 0);
				@(negedge clk);
			end
		end
		rxd  = 1'b0;
		stop = 1'b0;
	endtask

	task automatic driveGap(input int g);
		rxd = 1'b0;
		repeat (g) @(negedge clk);
	endtask

	task automatic readByte(input int adr, output logic [7:0] val);
		rdAdr = irRxPkg::memAdrWidth'(adr);
		@(negedge clk);	// Combinational port, settled by now
		val = rdData;
	endtask

	task automatic readCode(input int adr, output int code);
		logic [7:0] lsb, msb;
		readByte(adr, lsb);	// LSB first in memory
		readByte(adr + 1, msb);
		code = {16'd0, msb, lsb};
	endtask

	// Waits a bounded number of cycles for the interrupt
	task automatic waitIrq(input int maxCycles, output logic seen);
		int n;
		n = 0;
		while ((irq !== 1'b1) && (n < maxCycles)) begin
			@(negedge clk);
			n++;
		end
		seen = (irq === 1'b1);
	endtask

	// Clear passes 2 sync flops plus the register
	task automatic dropIrq();
		checkCond(irq === 1'b1, "int_o not high before clear_i");
		clear = 1'b1;
		@(negedge clk);
		clear = 1'b0;
		repeat (2) @(negedge clk);
		checkCond(irq === 1'b0, "int_o still high 3 cycles after clear_i");
	endtask

	//*********************************************************************
	// Test sequence
	//*********************************************************************
	initial begin
		int         errBefore;
		int         code;
		int         expCode [$];
		logic [7:0] snap [16];
		logic [7:0] b;
		logic       irqSeen;

		// Frames drawn up front
		nA[0] = 16 + drawBits(4);	// Room for offset and sample rises
		for (int i = 1; i < 4; i++)
			nA[i] = 8 + drawBits(4);
		for (int i = 0; i < 3; i++)
			gA[i] = pA * (3 + drawBits(3)) + drawBits(4);
		p5 = 16 + 2 * drawBits(3);
		n5 = 24 + drawBits(3);
		p6 = 16 + 2 * drawBits(3);
		n6[0] = 16 + drawBits(4);
		for (int i = 1; i < 3; i++)
			n6[i] = 8 + drawBits(4);
		for (int i = 0; i < 2; i++)
			g6[i] = p6 * (3 + drawBits(3)) + drawBits(4);

		// Frame lengths plus the 4096-cycle OFF timeout
		runLimit = 2000 + 4100 * pA + n5 * p5;
		for (int i = 0; i < 4; i++)
			runLimit += nA[i] * pA;
		for (int i = 0; i < 3; i++)
			runLimit += gA[i] + n6[i] * p6;
		for (int i = 0; i < 2; i++)
			runLimit += g6[i];

		// First ON code counted only after 2 offset and 8 sample rises
		expCode.push_back(nA[0] - 10);
		for (int i = 0; i < 3; i++) begin
			expCode.push_back(roundDiv(gA[i], pA));
			expCode.push_back(nA[i + 1]);
		end

		rst        = 1'b1;
		start      = 1'b0;
		stop       = 1'b0;
		rxd        = 1'b0;
		clear      = 1'b0;
		offsetLen  = 2'd1;	// 2 rises
		sampleLen  = 2'd1;	// 8 rises
		offTimeout = 4'd1;	// 4096 carrier cycles
		limitAdr   = '1;
		rdAdr      = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// 1 Reset values and receive flag
		testName  = "reset_start";
		errBefore = errCount;
		checkCond(rxOn === 1'b0, "rxOn_o not low after reset");
		checkCond(irq === 1'b0, "int_o not low after reset");
		checkEq("end address after reset", 0, int'(codeEndAdr));
		startRx();
		checkCond(rxOn === 1'b1, "rxOn_o not high one cycle after start_i");
		finishTest(errBefore);

		// Reception ended by OFF timeout after the last burst
		for (int i = 0; i < 4; i++) begin
			driveBurst(nA[i], pA, -1);
			if (i < 3)
				driveGap(gA[i]);
		end
		waitIrq(4100 * pA, irqSeen);

		// 2 Averaging then first ON code
		testName  = "averaging";
		errBefore = errCount;
		readCode(0, code);
		checkNear("first ON code", expCode[0], code);
		finishTest(errBefore);

		// 3 Later ON and OFF codes
		testName  = "code_readback";
		errBefore = errCount;
		for (int i = 1; i < expCode.size(); i++) begin
			readCode(2 * i, code);
			checkNear($sformatf("code %0d", i), expCode[i], code);
		end
		finishTest(errBefore);

		// 4 OFF timeout, the timeout OFF code is the last one written
		testName  = "off_timeout";
		errBefore = errCount;
		checkCond(irqSeen, "int_o did not rise on OFF timeout");
		checkCond(rxOn === 1'b0, "rxOn_o still high after OFF timeout");
		readCode(2 * expCode.size(), code);
		checkEq("timeout OFF code", 4096 * int'(offTimeout), code);
		checkEq("end address", 2 * (expCode.size() + 1), int'(codeEndAdr));
		dropIrq();
		finishTest(errBefore);

		// 5 Stop strobe inside a burst, then interrupt clear
		testName  = "stop_clear";
		errBefore = errCount;
		startRx();
		driveBurst(n5, p5, 16);	// Past averaging, in an ON code
		waitIrq(4, irqSeen);
		checkCond(irqSeen, "int_o did not rise after stop_i");
		checkCond(rxOn === 1'b0, "rxOn_o still high after stop_i");
		checkEq("end address", 0, int'(codeEndAdr));
		dropIrq();
		finishTest(errBefore);

		// 6 Memory limit, three codes fit below address 6
		testName  = "mem_limit";
		errBefore = errCount;
		for (int a = 0; a < 16; a++)
			readByte(6 + a, snap[a]);	// Contents left by earlier receptions
		expCode.delete();
		expCode.push_back(n6[0] - 10);
		expCode.push_back(roundDiv(g6[0], p6));
		expCode.push_back(n6[1]);
		limitAdr = 8'd6;
		startRx();
		driveBurst(n6[0], p6, -1);
		driveGap(g6[0]);
		driveBurst(n6[1], p6, -1);
		driveGap(g6[1]);
		driveBurst(n6[2], p6, -1);	// Its first rise ends reception
		waitIrq(4, irqSeen);
		checkCond(irqSeen, "int_o did not rise at memory limit");
		checkCond(rxOn === 1'b0, "rxOn_o still high at memory limit");
		checkEq("end address", 2 * expCode.size(), int'(codeEndAdr));
		for (int i = 0; i < expCode.size(); i++) begin
			readCode(2 * i, code);
			checkNear($sformatf("code %0d", i), expCode[i], code);
		end
		for (int a = 0; a < 16; a++) begin
			readByte(6 + a, b);
			checkCond(b === snap[a], $sformatf("address %0d written at or above limit", 6 + a));
		end
		dropIrq();
		finishTest(errBefore);

		$display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errCount);
		if (errCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
irRxPkg.sv
irCountBus.sv
irCycleCounters.sv
irCarrierAvg.sv
irRxFsm.sv
irCodeWriter.sv
irRxTop.sv
tbIrRx.sv

// ==== Makefile ====
sim:
	verilator --binary --assert -Wno-fatal --top-module tbIrRx -f compile.f -o tbIrRx
	./obj_dir/tbIrRx | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
